/* common/slurm_defs.svh */
// slurm shared widths and fixed register numbers for the issue interlock

`ifndef SLURM_DEFS_SVH
`define SLURM_DEFS_SVH

// instruction word width
`define SLURM_BITS 16

// width of a register select field, sixteen registers
`define SLURM_REG_BITS 4

// register zero reads as constant, never a hazard source or target
`define SLURM_R0 4'd0

// written by a branch with link
`define SLURM_LINK_REG 4'd15

`endif

/* common/slurm_pkg.sv */
// slurm types and instruction field decoding shared by the issue interlock

`default_nettype none

`include "slurm_defs.svh"

package slurm_pkg;

	typedef logic [`SLURM_REG_BITS-1:0] reg_sel_t;

	// top nibble of the word, 9 to 15 decode as nop
	typedef enum logic [3:0] {
		NOP         = 4'd0,
		ALU_SINGLE  = 4'd1,
		ALU_REG_REG = 4'd2,
		ALU_REG_IMM = 4'd3,
		BRANCH      = 4'd4,
		LOAD        = 4'd5,
		STORE       = 4'd6,
		PEEK        = 4'd7,
		POKE        = 4'd8
	} opcode_t;

	typedef struct packed {
		opcode_t  opcode;
		reg_sel_t rd;
		reg_sel_t ra;
		reg_sel_t rb;	// rb, or imm for the immediate form
	} reg_fmt_t;

	typedef struct packed {
		opcode_t                  opcode;
		logic [3:0]               cond;	// 0 = always
		logic                     link;
		logic [`SLURM_BITS-10:0]  offset;	// rest of the word after opcode, cond, link
	} branch_fmt_t;

	typedef union packed {
		reg_fmt_t    rfmt;
		branch_fmt_t bfmt;
	} slurm_instr_u;

	// travels with an instruction through stages 1 to 3
	typedef struct packed {
		reg_sel_t dest;	// R0 when nothing is written
		logic     modifies_flags;
	} hazard_tag_t;

	function automatic reg_sel_t dest_of(slurm_instr_u i);
		case (i.rfmt.opcode)
			ALU_SINGLE, ALU_REG_REG, ALU_REG_IMM: return i.rfmt.rd;
			BRANCH:      return i.bfmt.link ? `SLURM_LINK_REG : `SLURM_R0;
			LOAD, PEEK:  return i.rfmt.rd;
			default:     return `SLURM_R0;
		endcase
	endfunction

	function automatic reg_sel_t sel_a_of(slurm_instr_u i);
		case (i.rfmt.opcode)
			ALU_SINGLE:                       return i.rfmt.rd;	// single reg op reads its own dest
			ALU_REG_REG, ALU_REG_IMM:         return i.rfmt.ra;
			LOAD, STORE, PEEK, POKE:          return i.rfmt.ra;	// address base
			default:                          return `SLURM_R0;
		endcase
	endfunction

	function automatic reg_sel_t sel_b_of(slurm_instr_u i);
		case (i.rfmt.opcode)
			ALU_REG_REG:  return i.rfmt.rb;
			STORE, POKE:  return i.rfmt.rd;	// data to be written out
			default:      return `SLURM_R0;
		endcase
	endfunction

	function automatic logic writes_flags_of(slurm_instr_u i);
		return i.rfmt.opcode inside {ALU_SINGLE, ALU_REG_REG, ALU_REG_IMM};
	endfunction

	function automatic logic uses_flags_of(slurm_instr_u i);
		return (i.bfmt.opcode == BRANCH) && (i.bfmt.cond != 4'd0);
	endfunction

endpackage

`default_nettype wire

/* rtl/hazard/slurm_hazard.sv */
// slurm hazard unit, p0 tag generation, in-flight compare and stall flag

`default_nettype none

`include "slurm_defs.svh"

module slurm_hazard import slurm_pkg::*; (
	input  wire                        CLK,
	input  wire                        RSTb,

	input  wire                        is_executing,
	input  wire                        load_pc,

	// p0 slot
	input  wire                        p0_valid,
	input  wire slurm_instr_u          p0_instr,
	input  wire [`SLURM_REG_BITS-1:0]  sel_a,
	input  wire [`SLURM_REG_BITS-1:0]  sel_b,

	// tag leaving p0 and tags still in flight
	output hazard_tag_t                tag0,
	input  wire hazard_tag_t           tag1,
	input  wire hazard_tag_t           tag2,
	input  wire hazard_tag_t           tag3,

	output logic                       hazard,
	output logic                       stall
);

	hazard_tag_t in_flight [3];
	logic        reg_hit;
	logic        flag_hit;
	logic        p0_uses_flags;

	logic stall_r;
	logic prev_stall_r;

	// what p0 will write once it issues
	assign tag0.dest           = dest_of(p0_instr);
	assign tag0.modifies_flags = writes_flags_of(p0_instr);

	assign in_flight[0] = tag1;
	assign in_flight[1] = tag2;
	assign in_flight[2] = tag3;

	assign p0_uses_flags = uses_flags_of(p0_instr);

	always_comb begin
		reg_hit  = 1'b0;
		flag_hit = 1'b0;
		for (int k = 0; k < 3; k++) begin
			if (sel_a != `SLURM_R0 && sel_a == in_flight[k].dest)
				reg_hit = 1'b1;
			if (sel_b != `SLURM_R0 && sel_b == in_flight[k].dest)
				reg_hit = 1'b1;
			if (in_flight[k].modifies_flags)
				flag_hit = 1'b1;
		end
	end

	// hold p0 until every conflicting writer has left stage 3
	assign hazard = p0_valid && (reg_hit || (p0_uses_flags && flag_hit));

	// stall_r follows hazard only while executing, prev_stall_r stretches it one cycle
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			stall_r      <= 1'b0;
			prev_stall_r <= 1'b0;
		end else if (load_pc) begin
			stall_r      <= 1'b0;
			prev_stall_r <= 1'b0;
		end else begin
			prev_stall_r <= stall_r;
			if (is_executing)
				stall_r <= hazard;	// set on hazard, cleared once it is gone
		end
	end

	assign stall = stall_r || prev_stall_r;

	// stall can only come up from a hazard seen while executing
	a_stall_needs_hazard: assert property (
		@(posedge CLK) disable iff (!RSTb)
		$rose(stall) |-> $past(hazard && is_executing)
	) else $error("stall rose without a hazard in the previous cycle");

endmodule

`default_nettype wire

/* rtl/hazard/slurm_hazard_track.sv */
// slurm hazard tag pipeline, carries p0 tags through stages 1 to 3

`default_nettype none

`include "slurm_defs.svh"

module slurm_hazard_track import slurm_pkg::*; (
	input  wire              CLK,
	input  wire              RSTb,

	input  wire              load_pc,
	input  wire              issue,	// p0 leaves the slot this cycle

	input  wire hazard_tag_t tag0,
	output hazard_tag_t      tag1,
	output hazard_tag_t      tag2,
	output hazard_tag_t      tag3
);

	// a bubble writes nothing and touches no flags
	localparam hazard_tag_t TAG_EMPTY = '{dest: `SLURM_R0, modifies_flags: 1'b0};

	always_ff @(posedge CLK) begin
		if (!RSTb || load_pc) begin
			tag1 <= TAG_EMPTY;
			tag2 <= TAG_EMPTY;
			tag3 <= TAG_EMPTY;
		end else begin
			tag1 <= issue ? tag0 : TAG_EMPTY;	// bubble when p0 held or empty
			tag2 <= tag1;
			tag3 <= tag2;	// tag3 falls off next cycle
		end
	end

	// a flush leaves nothing in flight for the next instruction
	a_flush_clears_tags: assert property (
		@(posedge CLK) disable iff (!RSTb)
		load_pc |=> (tag1 == TAG_EMPTY && tag2 == TAG_EMPTY && tag3 == TAG_EMPTY)
	) else $error("hazard tags not empty after load_pc");

endmodule

`default_nettype wire

/* rtl/slurm_issue.sv */
// slurm p0 issue slot, one-entry holding register between fetch and execute

`default_nettype none

`include "slurm_defs.svh"

module slurm_issue import slurm_pkg::*; (
	input  wire                        CLK,
	input  wire                        RSTb,

	// instruction stream in
	input  wire                        in_valid,
	input  wire slurm_instr_u          in_instr,
	output logic                       in_ready,

	input  wire                        hazard,
	input  wire                        load_pc,

	// p0 contents for the hazard unit
	output logic                       p0_valid,
	output slurm_instr_u               p0_instr,
	output logic [`SLURM_REG_BITS-1:0] sel_a,
	output logic [`SLURM_REG_BITS-1:0] sel_b,

	// issued instruction, execute always takes it
	output logic                       out_valid,
	output slurm_instr_u               out_instr
);

	logic take;

	// issue whenever p0 holds something the tags do not block
	assign out_valid = p0_valid && !hazard && !load_pc;
	assign out_instr = p0_instr;

	// room when empty or when the current entry leaves this cycle
	assign in_ready = !p0_valid || out_valid;
	assign take     = in_valid && in_ready;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			p0_valid <= 1'b0;
		end else if (load_pc) begin
			p0_valid <= 1'b0;	// beat taken now is from the old stream, drop it too
		end else if (take) begin
			p0_valid <= 1'b1;
		end else if (out_valid) begin
			p0_valid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (take)
			p0_instr <= in_instr;
	end

	// registers p0 will read
	assign sel_a = sel_a_of(p0_instr);
	assign sel_b = sel_b_of(p0_instr);

	// a held instruction must not change under the hazard unit
	a_p0_stable: assert property (
		@(posedge CLK) disable iff (!RSTb)
		(p0_valid && !out_valid && !load_pc) |=> $stable(p0_instr)
	) else $error("p0_instr changed while held");

endmodule

`default_nettype wire

/* rtl/slurm_interlock_top.sv */
// slurm issue interlock top, issue slot with hazard unit and tag pipeline

`default_nettype none

`include "slurm_defs.svh"

module slurm_interlock_top import slurm_pkg::*; (
	input  wire               CLK,
	input  wire               RSTb,

	input  wire               is_executing,
	input  wire               load_pc,

	input  wire               in_valid,
	input  wire slurm_instr_u in_instr,
	output logic              in_ready,

	output logic              out_valid,
	output slurm_instr_u      out_instr,

	output logic              stall
);

	logic                       hazard;
	logic                       p0_valid;
	slurm_instr_u               p0_instr;
	logic [`SLURM_REG_BITS-1:0] sel_a;
	logic [`SLURM_REG_BITS-1:0] sel_b;
	hazard_tag_t                tag0;
	hazard_tag_t                tag1;
	hazard_tag_t                tag2;
	hazard_tag_t                tag3;

	slurm_issue issue0 (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.in_valid  (in_valid),
		.in_instr  (in_instr),
		.in_ready  (in_ready),
		.hazard    (hazard),
		.load_pc   (load_pc),
		.p0_valid  (p0_valid),
		.p0_instr  (p0_instr),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.out_valid (out_valid),
		.out_instr (out_instr)
	);

	slurm_hazard hazard0 (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.is_executing (is_executing),
		.load_pc      (load_pc),
		.p0_valid     (p0_valid),
		.p0_instr     (p0_instr),
		.sel_a        (sel_a),
		.sel_b        (sel_b),
		.tag0         (tag0),
		.tag1         (tag1),
		.tag2         (tag2),
		.tag3         (tag3),
		.hazard       (hazard),
		.stall        (stall)
	);

	// tag of p0 enters stage 1 only in the cycle it issues
	slurm_hazard_track track0 (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.load_pc (load_pc),
		.issue   (out_valid),
		.tag0    (tag0),
		.tag1    (tag1),
		.tag2    (tag2),
		.tag3    (tag3)
	);

endmodule

`default_nettype wire

/* bench/slurm_interlock_tb.sv */
// slurm issue interlock testbench, random and directed traffic checked against a cycle model

`default_nettype none

`include "slurm_defs.svh"

module slurm_interlock_tb import slurm_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_ORDER = 2000;
	localparam int N_REG   = 600;
	localparam int N_FLAG  = 150;	// groups of four
	localparam int N_LINK  = 150;	// groups of four
	localparam int N_STALL = 600;
	localparam int N_FLUSH = 600;
	localparam int N_INSTR = N_ORDER + N_REG + 4 * N_FLAG + 4 * N_LINK + N_STALL + N_FLUSH;
	// worst case per instruction is one gap, three hazard cycles and the issue
	localparam int STIM_CYCLES = 5 * N_INSTR + 8;
	localparam int CYCLE_LIMIT = 4 * STIM_CYCLES + 100;

	logic         CLK;
	logic         RSTb;
	logic         is_executing;
	logic         load_pc;
	logic         in_valid;
	slurm_instr_u in_instr;
	logic         in_ready;
	logic         out_valid;
	slurm_instr_u out_instr;
	logic         stall;

	// stimulus side
	logic [`SLURM_BITS-1:0] stim_q [$];
	int                     valid_pct;
	int                     exec_pct;
	int                     flush_pct;
	bit                     beat_pending;
	int                     phase;

	// model side, advanced at the falling edge
	logic [`SLURM_BITS-1:0]     model_q [$];
	logic [`SLURM_REG_BITS-1:0] m_dest [1:3];
	bit                         m_flag [1:3];
	bit                         st_r;
	bit                         st_prev;
	bit                         after_flush;
	bit                         xfer_seen;
	bit                         checking;

	int    errors [1:6];
	int    issued [1:6];
	string test_name [1:6];
	int    cycle_count;

	slurm_interlock_top dut0 (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.is_executing (is_executing),
		.load_pc      (load_pc),
		.in_valid     (in_valid),
		.in_instr     (in_instr),
		.in_ready     (in_ready),
		.out_valid    (out_valid),
		.out_instr    (out_instr),
		.stall        (stall)
	);

	always #50 CLK = ~CLK;

	function automatic logic [`SLURM_REG_BITS-1:0] written_reg(logic [`SLURM_BITS-1:0] w);
		case (w[15:12])
			ALU_SINGLE, ALU_REG_REG, ALU_REG_IMM, LOAD, PEEK: return w[11:8];
			BRANCH:  return w[7] ? `SLURM_LINK_REG : `SLURM_R0;	// link bit
			default: return `SLURM_R0;
		endcase
	endfunction

	function automatic logic [`SLURM_REG_BITS-1:0] first_read(logic [`SLURM_BITS-1:0] w);
		case (w[15:12])
			ALU_SINGLE: return w[11:8];
			ALU_REG_REG, ALU_REG_IMM, LOAD, STORE, PEEK, POKE: return w[7:4];
			default: return `SLURM_R0;
		endcase
	endfunction

	function automatic logic [`SLURM_REG_BITS-1:0] second_read(logic [`SLURM_BITS-1:0] w);
		case (w[15:12])
			ALU_REG_REG: return w[3:0];
			STORE, POKE: return w[11:8];
			default:     return `SLURM_R0;
		endcase
	endfunction

	function automatic bit sets_flags(logic [`SLURM_BITS-1:0] w);
		return w[15:12] >= 4'd1 && w[15:12] <= 4'd3;
	endfunction

	function automatic bit needs_flags(logic [`SLURM_BITS-1:0] w);
		return w[15:12] == BRANCH && w[11:8] != 4'd0;
	endfunction

	// any read of w against the three model tags
	function automatic bit reg_conflict(logic [`SLURM_BITS-1:0] w);
		logic [`SLURM_REG_BITS-1:0] a;
		logic [`SLURM_REG_BITS-1:0] b;
		bit                         hit;
		a   = first_read(w);
		b   = second_read(w);
		hit = 1'b0;
		for (int k = 1; k <= 3; k++) begin
			if (a != `SLURM_R0 && a == m_dest[k])
				hit = 1'b1;
			if (b != `SLURM_R0 && b == m_dest[k])
				hit = 1'b1;
		end
		return hit;
	endfunction

	function automatic logic [`SLURM_BITS-1:0] random_instr(int span);
		logic [3:0] op;
		op = 4'($urandom % 12);	// 9 to 11 decode as nop
		return {op, 4'($urandom % span), 4'($urandom % span), 4'($urandom % span)};
	endfunction

	task automatic log_error(string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		errors[phase]++;
	endtask

	task automatic drive_cycle();
		logic [`SLURM_BITS-1:0] next_word;
		if (beat_pending && xfer_seen)
			beat_pending = 1'b0;
		if (!beat_pending && stim_q.size() > 0 && ($urandom % 100) < valid_pct) begin
			next_word    = stim_q.pop_front();
			in_instr     <= next_word;
			in_valid     <= 1'b1;
			beat_pending = 1'b1;
		end else if (!beat_pending) begin
			in_valid <= 1'b0;
		end
		load_pc      <= ($urandom % 100) < flush_pct;
		is_executing <= ($urandom % 100) < exec_pct;
	endtask

	task automatic run_phase(int num, int vp, int ep, int fp);
		int offered;
		phase     = num;
		valid_pct = vp;
		exec_pct  = ep;
		flush_pct = fp;
		offered   = stim_q.size();
		do begin
			@(posedge CLK);
			drive_cycle();
		end while (stim_q.size() > 0 || beat_pending || model_q.size() > 0);
		if (fp == 0) begin
			assert (issued[num] == offered)
				else log_error($sformatf("%0d offered but %0d issued", offered, issued[num]));
		end
		$display("test %0d %-20s %5d issued, %0d errors", num, test_name[num], issued[num],
			errors[num]);
	endtask

	always @(negedge CLK) begin : model_step
		logic [`SLURM_BITS-1:0] p0;
		bit p0_v;
		bit reg_hit;
		bit flag_hit;
		bit hz;
		bit exp_ov;
		bit exp_ready;
		bit exp_stall;
		if (checking) begin
			p0_v      = model_q.size() > 0;
			p0        = p0_v ? model_q[0] : '0;
			reg_hit   = p0_v && reg_conflict(p0);
			flag_hit  = p0_v && needs_flags(p0) && (m_flag[1] || m_flag[2] || m_flag[3]);
			hz        = reg_hit || flag_hit;
			exp_ov    = p0_v && !hz && !load_pc;
			exp_ready = !p0_v || exp_ov;
			exp_stall = st_r || st_prev;

			assert (out_valid === exp_ov)
				else log_error($sformatf("out_valid %b, model expects %b", out_valid, exp_ov));
			assert (in_ready === exp_ready)
				else log_error($sformatf("in_ready %b, model expects %b", in_ready, exp_ready));
			assert (stall === exp_stall)
				else log_error($sformatf("stall %b, model expects %b", stall, exp_stall));
			if (out_valid) begin
				assert (p0_v && out_instr === p0)
					else log_error($sformatf("issued %h, model expects %h", out_instr, p0));
				assert (!reg_hit)
					else log_error($sformatf("%h issued over a register in flight", out_instr));
				assert (!flag_hit)
					else log_error($sformatf("%h issued while flags in flight", out_instr));
				issued[phase]++;
			end
			if (after_flush) begin
				assert (in_ready && !stall)
					else log_error("in_ready low or stall high after load_pc");
			end

			// advance the model across the next rising edge
			xfer_seen = in_valid && in_ready;
			m_dest[3] = m_dest[2];
			m_flag[3] = m_flag[2];
			m_dest[2] = m_dest[1];
			m_flag[2] = m_flag[1];
			m_dest[1] = exp_ov ? written_reg(p0) : `SLURM_R0;	// bubble otherwise
			m_flag[1] = exp_ov && sets_flags(p0);
			if (exp_ov)
				void'(model_q.pop_front());
			if (load_pc) begin
				model_q.delete();	// a beat taken in this cycle is dropped as well
				for (int k = 1; k <= 3; k++) begin
					m_dest[k] = `SLURM_R0;
					m_flag[k] = 1'b0;
				end
				st_r    = 1'b0;
				st_prev = 1'b0;
			end else begin
				if (xfer_seen)
					model_q.push_back(in_instr);
				st_prev = st_r;
				if (is_executing)
					st_r = hz;
			end
			after_flush = load_pc;
		end
	end

	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		int failed;
		int total;
		CLK          = 1'b0;
		RSTb         = 1'b0;
		is_executing = 1'b0;
		load_pc      = 1'b0;
		in_valid     = 1'b0;
		in_instr     = '0;
		phase        = 1;
		for (int k = 1; k <= 3; k++)
			m_dest[k] = `SLURM_R0;
		test_name[1] = "order and integrity";
		test_name[2] = "register hazard";
		test_name[3] = "flag hazard";
		test_name[4] = "r0 and link register";
		test_name[5] = "stall flag";
		test_name[6] = "flush";
		void'($urandom(32'h7ac23474));

		repeat (8) @(posedge CLK);
		RSTb     <= 1'b1;
		checking = 1'b1;

		for (int i = 0; i < N_ORDER; i++)
			stim_q.push_back(random_instr(16));
		run_phase(1, 70, 100, 0);

		for (int i = 0; i < N_REG; i++)
			stim_q.push_back(random_instr(4));	// few registers, many conflicts
		run_phase(2, 85, 100, 0);

		for (int i = 0; i < N_FLAG; i++) begin
			stim_q.push_back({4'($urandom % 3 + 1), 4'($urandom % 16), 8'($urandom)});
			stim_q.push_back({BRANCH, 4'($urandom % 3), 1'b0, 7'($urandom)});	// cond 0 is always
			stim_q.push_back(random_instr(16));
			stim_q.push_back(random_instr(16));
		end
		run_phase(3, 85, 100, 0);

		for (int i = 0; i < N_LINK; i++) begin
			stim_q.push_back({ALU_REG_IMM, `SLURM_R0, 4'($urandom % 16), 4'($urandom % 16)});
			stim_q.push_back({ALU_REG_REG, 4'($urandom % 16), `SLURM_R0, `SLURM_R0});
			stim_q.push_back({BRANCH, 4'd0, 1'b1, 7'($urandom)});
			stim_q.push_back({ALU_REG_IMM, 4'($urandom % 16), `SLURM_LINK_REG, 4'($urandom % 16)});
		end
		run_phase(4, 90, 100, 0);

		for (int i = 0; i < N_STALL; i++)
			stim_q.push_back(random_instr(4));
		run_phase(5, 80, 50, 0);

		for (int i = 0; i < N_FLUSH; i++)
			stim_q.push_back(random_instr(8));
		run_phase(6, 80, 100, 5);

		failed = 0;
		total  = 0;
		for (int t = 1; t <= 6; t++) begin
			total += errors[t];
			if (errors[t] != 0)
				failed++;
		end
		$display("%0d tests run, %0d failed, %0d errors", 6, failed, total);
		if (total == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* slurm_interlock.f */
+incdir+common
common/slurm_pkg.sv
rtl/hazard/slurm_hazard.sv
rtl/hazard/slurm_hazard_track.sv
rtl/slurm_issue.sv
rtl/slurm_interlock_top.sv
bench/slurm_interlock_tb.sv

/* Bender.yml */
package:
  name: slurm_interlock

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/slurm_pkg.sv
      - rtl/hazard/slurm_hazard.sv
      - rtl/hazard/slurm_hazard_track.sv
      - rtl/slurm_issue.sv
      - rtl/slurm_interlock_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/slurm_interlock_tb.sv
